/* sim.f */
rtl/soc_pkg.sv
rtl/block_ram.sv
rtl/uart.sv
rtl/hex_display.sv
rtl/bus_decode.sv
rtl/soc_bus_top.sv
testbench/soc_bus_props.sv
testbench/soc_bus_tb.sv

/* testbench/soc_bus_tb.sv */
`default_nettype none

module soc_bus_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import soc_pkg::*;

   localparam int TB_RAM_ASIZE = 10;
   localparam int BIT_CYCLES   = 16;
   // Room for four UART frames, 64 RAM accesses and a few display scans with wide margin
   localparam int MAX_CYCLES   = 6000;
   localparam logic [ASIZE-1:0] DATA_ADDR   = {15'd0, UART_DATA_REG};
   localparam logic [ASIZE-1:0] STATUS_ADDR = {15'd0, UART_STATUS_REG};

   logic             cpu_clk;
   logic             reset;
   logic [ASIZE-1:0] address;
   logic             rnw;
   logic             vpa;
   logic             vda;
   logic             vio;
   logic [DSIZE-1:0] cpu_dout;
   logic [DSIZE-1:0] cpu_din;
   logic             rxd;
   logic             txd;
   logic             show_data;
   logic [6:0]       seg;
   logic [3:0]       an;
   // Serial line source is the TX loopback or a driven level
   logic             loop_en;
   logic             rx_line;

   integer seed;
   int     cycle_count;
   int     error_count;
   int     errors_at_start;
   int     pass_count;
   int     fail_count;
   string  test_name;

   soc_bus_top #(
      .CLKSPEED     (1843200),
      .BAUD         (115200),
      .DIGIT_CYCLES (8),
      .RAM_ASIZE    (TB_RAM_ASIZE)
   ) UUT (
      .cpu_clk   (cpu_clk),
      .reset     (reset),
      .address   (address),
      .rnw       (rnw),
      .vpa       (vpa),
      .vda       (vda),
      .vio       (vio),
      .cpu_dout  (cpu_dout),
      .cpu_din   (cpu_din),
      .rxd       (rxd),
      .txd       (txd),
      .show_data (show_data),
      .seg       (seg),
      .an        (an)
   );

   bind soc_bus_top soc_bus_props u_props (
      .cpu_clk  (cpu_clk),
      .reset    (reset),
      .txd      (txd),
      .tx_state (u_uart.tx_state),
      .an       (an),
      .ram_cs   (ram_cs),
      .uart_cs  (uart_cs)
   );

   assign rxd = loop_en ? txd : rx_line;

   always #2 cpu_clk = ~cpu_clk;

   // Run limit
   always @(posedge cpu_clk) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Run stopped after %0d cycles without finishing", cycle_count);
         $display("tests failed");
         $finish;
      end
   end

   // ------------------------------------------------------------------------
   // Bus master
   // ------------------------------------------------------------------------

   task automatic drive_bus(input logic io, input logic read, input logic [ASIZE-1:0] addr,
                            input logic [DSIZE-1:0] wdata);
      address  = addr;
      rnw      = read;
      vpa      = !io && read;
      vda      = !io && !read;
      vio      = io;
      cpu_dout = wdata;
   endtask

   task automatic release_bus();
      vpa = 1'b0;
      vda = 1'b0;
      vio = 1'b0;
      rnw = 1'b1;
   endtask

   task automatic bus_write(input logic io, input logic [ASIZE-1:0] addr,
                            input logic [DSIZE-1:0] wdata);
      @(negedge cpu_clk);
      drive_bus(io, 1'b0, addr, wdata);
      @(negedge cpu_clk);
      release_bus();
   endtask

   // Read data is valid in the cycle after the access
   task automatic bus_read(input logic io, input logic [ASIZE-1:0] addr,
                           output logic [DSIZE-1:0] rdata);
      @(negedge cpu_clk);
      drive_bus(io, 1'b1, addr, '0);
      @(negedge cpu_clk);
      rdata = cpu_din;
      release_bus();
   endtask

   // ------------------------------------------------------------------------
   // Checks and reporting
   // ------------------------------------------------------------------------

   task automatic check_word(input logic [DSIZE-1:0] expected, input logic [DSIZE-1:0] actual);
      if (actual !== expected) begin
         $display("Error in %s: expected %h, actual %h", test_name, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_byte(input logic [7:0] expected, input logic [7:0] actual);
      if (actual !== expected) begin
         $display("Error in %s: expected %h, actual %h", test_name, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_bit(input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("Error in %s: expected %b, actual %b", test_name, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_display(input logic [6:0] exp_seg, input logic [3:0] exp_an,
                                input logic [6:0] act_seg, input logic [3:0] act_an);
      if (act_seg !== exp_seg || act_an !== exp_an) begin
         $display("Error in %s: expected seg %b an %b, actual seg %b an %b",
                  test_name, exp_seg, exp_an, act_seg, act_an);
         error_count++;
      end
   endtask

   task automatic start_test(input string name);
      test_name       = name;
      errors_at_start = error_count;
   endtask

   task automatic end_test();
      if (error_count == errors_at_start) begin
         pass_count++;
         $display("Test %s ok", test_name);
      end else begin
         fail_count++;
         $display("Test %s bad, %0d errors", test_name, error_count - errors_at_start);
      end
   endtask

   // ------------------------------------------------------------------------
   // Waits with their own limits
   // ------------------------------------------------------------------------

   // Polls the status register until one bit reaches a level
   task automatic wait_status_bit(input int bit_pos, input logic level, input int max_polls);
      logic [DSIZE-1:0] status;
      int               polls;
      polls = 0;
      bus_read(1'b1, STATUS_ADDR, status);
      while (status[bit_pos] !== level && polls < max_polls) begin
         bus_read(1'b1, STATUS_ADDR, status);
         polls++;
      end
      if (status[bit_pos] !== level) begin
         $display("Status bit %0d never reached %b in %s", bit_pos, level, test_name);
         error_count++;
      end
   endtask

   task automatic wait_tx_start();
      int n;
      n = 0;
      while (txd !== 1'b0 && n < 40) begin
         @(negedge cpu_clk);
         n++;
      end
      if (txd !== 1'b0) begin
         $display("No start bit on txd in %s", test_name);
         error_count++;
      end
   endtask

   // Returns just after the anode switches onto digit k
   task automatic wait_digit(input int k);
      logic [3:0] pattern;
      int         n;
      pattern = ~(4'b0001 << k);
      n = 0;
      while (an === pattern && n < 64) begin
         @(negedge cpu_clk);
         n++;
      end
      while (an !== pattern && n < 64) begin
         @(negedge cpu_clk);
         n++;
      end
      if (n >= 64) begin
         $display("Display never reached digit %0d in %s", k, test_name);
         error_count++;
      end
   endtask

   // Start bit, eight data bits LSB first, stop bit
   task automatic send_serial(input logic [7:0] data);
      logic [9:0] frame;
      frame = {1'b1, data, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(negedge cpu_clk);
         rx_line = frame[i];
         repeat (BIT_CYCLES - 1) @(negedge cpu_clk);
      end
   endtask

   // ------------------------------------------------------------------------
   // Directed tests
   // ------------------------------------------------------------------------

   task automatic test_ram();
      logic [ASIZE-1:0] addrs [32];
      logic [DSIZE-1:0] model [1 << TB_RAM_ASIZE];
      logic [DSIZE-1:0] data;
      logic [31:0]      rnd;
      start_test("ram");
      for (int i = 0; i < 32; i++) begin
         rnd      = $random(seed);
         addrs[i] = rnd[15:0];
         rnd      = $random(seed);
         data     = rnd[15:0];
         // RAM mirrors, so only the low address bits pick a word
         model[addrs[i] % (1 << TB_RAM_ASIZE)] = data;
         bus_write(1'b0, addrs[i], data);
      end
      for (int i = 0; i < 32; i++) begin
         bus_read(1'b0, addrs[i], data);
         check_word(model[addrs[i] % (1 << TB_RAM_ASIZE)], data);
      end
      end_test();
   endtask

   task automatic test_reset_status();
      logic [DSIZE-1:0] data;
      start_test("status after reset");
      check_bit(1'b1, txd);
      bus_read(1'b1, STATUS_ADDR, data);
      check_word(16'h0000, data);
      check_bit(1'b1, txd);
      end_test();
   endtask

   task automatic test_transmit();
      logic [DSIZE-1:0] data;
      logic [7:0]       got;
      start_test("transmit");
      bus_write(1'b1, DATA_ADDR, 16'h00c5);
      wait_tx_start();
      // Busy during the frame
      bus_read(1'b1, STATUS_ADDR, data);
      check_word(16'h0001, data);
      // Second write while busy must be dropped
      bus_write(1'b1, DATA_ADDR, 16'h005a);
      // Move on to the middle of the start bit
      repeat (BIT_CYCLES / 2 - 5) @(negedge cpu_clk);
      check_bit(1'b0, txd);
      for (int i = 0; i < 8; i++) begin
         repeat (BIT_CYCLES) @(negedge cpu_clk);
         got[i] = txd;
      end
      check_byte(8'hc5, got);
      repeat (BIT_CYCLES) @(negedge cpu_clk);
      check_bit(1'b1, txd);
      wait_status_bit(STAT_TX_BUSY, 1'b0, 20);
      end_test();
   endtask

   task automatic test_receive();
      logic [DSIZE-1:0] data;
      logic [31:0]      rnd;
      start_test("receive");
      send_serial(8'h3c);
      wait_status_bit(STAT_RX_FULL, 1'b1, 40);
      bus_read(1'b1, DATA_ADDR, data);
      check_byte(8'h3c, data[7:0]);
      bus_read(1'b1, STATUS_ADDR, data);
      check_bit(1'b0, data[STAT_RX_FULL]);
      // Same again through the loopback
      rnd = $random(seed);
      @(negedge cpu_clk);
      loop_en = 1'b1;
      bus_write(1'b1, DATA_ADDR, {8'h00, rnd[7:0]});
      wait_status_bit(STAT_RX_FULL, 1'b1, 120);
      bus_read(1'b1, DATA_ADDR, data);
      check_byte(rnd[7:0], data[7:0]);
      bus_read(1'b1, STATUS_ADDR, data);
      check_bit(1'b0, data[STAT_RX_FULL]);
      wait_status_bit(STAT_TX_BUSY, 1'b0, 20);
      @(negedge cpu_clk);
      loop_en = 1'b0;
      end_test();
   endtask

   task automatic test_display();
      logic [ASIZE-1:0] addr;
      logic [DSIZE-1:0] word;
      addr = 16'h3a7c;
      word = 16'h5e19;
      start_test("display");
      bus_write(1'b0, addr, word);
      // Hold a read so both address and data stay put
      @(negedge cpu_clk);
      drive_bus(1'b0, 1'b1, addr, '0);
      show_data = 1'b0;
      repeat (2) @(negedge cpu_clk);
      for (int k = 0; k < 4; k++) begin
         wait_digit(k);
         check_display(hex_to_seg(addr[4*k +: 4]), ~(4'b0001 << k), seg, an);
      end
      show_data = 1'b1;
      for (int k = 0; k < 4; k++) begin
         wait_digit(k);
         check_display(hex_to_seg(word[4*k +: 4]), ~(4'b0001 << k), seg, an);
      end
      release_bus();
      show_data = 1'b0;
      end_test();
   endtask

   task automatic test_steering();
      logic [DSIZE-1:0] data;
      start_test("read steering");
      // Leave a non-zero word on the RAM output first
      bus_write(1'b0, 16'h0001, 16'hbeef);
      bus_read(1'b0, 16'h0001, data);
      check_word(16'hbeef, data);
      bus_read(1'b1, STATUS_ADDR, data);
      check_word(16'h0000, data);
      end_test();
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------

   initial begin
      seed        = 52264;
      cycle_count = 0;
      error_count = 0;
      pass_count  = 0;
      fail_count  = 0;
      cpu_clk     = 1'b0;
      reset       = 1'b1;
      address     = '0;
      rnw         = 1'b1;
      vpa         = 1'b0;
      vda         = 1'b0;
      vio         = 1'b0;
      cpu_dout    = '0;
      show_data   = 1'b0;
      loop_en     = 1'b0;
      rx_line     = 1'b1;
      repeat (16) @(negedge cpu_clk);
      reset = 1'b0;

      test_reset_status();
      test_ram();
      test_transmit();
      test_receive();
      test_display();
      test_steering();

      $display("Summary: %0d passing, %0d failing, %0d check errors, %0d assertion failures",
               pass_count, fail_count, error_count, UUT.u_props.violations);
      if (fail_count == 0 && error_count == 0 && UUT.u_props.violations == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/soc_bus_props.sv */
`default_nettype none

module soc_bus_props (
   input logic                    cpu_clk,
   input logic                    reset,
   input logic                    txd,
   input soc_pkg::uart_tx_state_t tx_state,
   input logic [3:0]              an,
   input logic                    ram_cs,
   input logic                    uart_cs
);

   timeunit 1ns;
   timeprecision 100ps;

   import soc_pkg::*;

   // Count of failed assertions
   int violations = 0;

   // Idle transmitter holds the line at mark
   assert property (@(posedge cpu_clk) disable iff (reset) (tx_state == TX_IDLE) |-> txd)
      else begin
         violations++;
         $error("txd low while the transmitter is idle");
      end

   // Exactly one digit lit
   assert property (@(posedge cpu_clk) disable iff (reset) $onehot(~an))
      else begin
         violations++;
         $error("anode pattern %b does not have exactly one low bit", an);
      end

   // Memory and IO cycles kept apart by the bus master
   assert property (@(posedge cpu_clk) disable iff (reset) !(ram_cs && uart_cs))
      else begin
         violations++;
         $error("RAM and UART selected in the same cycle");
      end

endmodule

`default_nettype wire

/* rtl/soc_bus_top.sv */
`default_nettype none

module soc_bus_top #(
   // Input clock rate and serial rate
   parameter int CLKSPEED     = 1843200,
   parameter int BAUD         = 115200,
   // Display scan rate in cycles per digit
   parameter int DIGIT_CYCLES = 8,
   parameter int RAM_ASIZE    = soc_pkg::RAM_ASIZE
) (
   input  logic                      cpu_clk,
   input  logic                      reset,
   // Lookahead bus from the CPU side
   input  logic [soc_pkg::ASIZE-1:0] address,
   input  logic                      rnw,
   input  logic                      vpa,
   input  logic                      vda,
   input  logic                      vio,
   input  logic [soc_pkg::DSIZE-1:0] cpu_dout,
   output logic [soc_pkg::DSIZE-1:0] cpu_din,
   // Serial port
   input  logic                      rxd,
   output logic                      txd,
   // Display
   input  logic                      show_data,
   output logic [6:0]                seg,
   output logic [3:0]                an
);

   import soc_pkg::*;

   // Bit time in cpu_clk cycles
   localparam int CLKS_PER_BIT = CLKSPEED / BAUD;

   logic             ram_cs;
   logic             uart_cs;
   logic [ASIZE-1:0] address_q;
   logic             rnw_q;
   logic [DSIZE-1:0] dout_q;
   logic [DSIZE-1:0] ram_dout;
   logic [7:0]       uart_dout;
   logic [15:0]      display_value;

   // ------------------------------------------------------------------------
   // Decode, lookahead registers and read data steering
   // ------------------------------------------------------------------------

   bus_decode u_decode (
      .cpu_clk   (cpu_clk),
      .reset     (reset),
      .address   (address),
      .rnw       (rnw),
      .vpa       (vpa),
      .vda       (vda),
      .vio       (vio),
      .cpu_dout  (cpu_dout),
      .ram_dout  (ram_dout),
      .uart_dout (uart_dout),
      .ram_cs    (ram_cs),
      .uart_cs   (uart_cs),
      .address_q (address_q),
      .rnw_q     (rnw_q),
      .dout_q    (dout_q),
      .cpu_din   (cpu_din)
   );

   // RAM sees the live lookahead bus, low address bits only
   block_ram #(
      .RAM_ASIZE (RAM_ASIZE)
   ) u_ram (
      .cpu_clk (cpu_clk),
      .cs      (ram_cs),
      .rnw     (rnw),
      .address (address[RAM_ASIZE-1:0]),
      .din     (cpu_dout),
      .dout    (ram_dout)
   );

   // UART works one cycle behind on the registered copies
   uart #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_uart (
      .cpu_clk (cpu_clk),
      .reset   (reset),
      .cs      (uart_cs),
      .rnw     (rnw_q),
      .a0      (address_q[0]),
      .din     (dout_q[7:0]),
      .dout    (uart_dout),
      .rxd     (rxd),
      .txd     (txd)
   );

   // Read data or registered address on the display
   assign display_value = show_data ? cpu_din[15:0] : address_q[15:0];

   hex_display #(
      .DIGIT_CYCLES (DIGIT_CYCLES)
   ) u_display (
      .cpu_clk (cpu_clk),
      .reset   (reset),
      .value   (display_value),
      .seg     (seg),
      .an      (an)
   );

endmodule

`default_nettype wire

/* rtl/bus_decode.sv */
`default_nettype none

module bus_decode (
   input  logic                      cpu_clk,
   input  logic                      reset,
   // Live lookahead bus
   input  logic [soc_pkg::ASIZE-1:0] address,
   input  logic                      rnw,
   input  logic                      vpa,
   input  logic                      vda,
   input  logic                      vio,
   input  logic [soc_pkg::DSIZE-1:0] cpu_dout,
   // Read data from the slaves
   input  logic [soc_pkg::DSIZE-1:0] ram_dout,
   input  logic [7:0]                uart_dout,
   // Selects and registered copies
   output logic                      ram_cs,
   output logic                      uart_cs,
   output logic [soc_pkg::ASIZE-1:0] address_q,
   output logic                      rnw_q,
   output logic [soc_pkg::DSIZE-1:0] dout_q,
   output logic [soc_pkg::DSIZE-1:0] cpu_din
);

   import soc_pkg::*;

   logic vio_q;

   // ------------------------------------------------------------------------
   // Chip selects
   // ------------------------------------------------------------------------

   // RAM answers any memory cycle, so it mirrors everywhere
   assign ram_cs = vpa | vda;

   // IO space goes to the UART one cycle late
   assign uart_cs = vio_q;

   // ------------------------------------------------------------------------
   // Lookahead registers for the UART
   // ------------------------------------------------------------------------

   // Strobes and address cleared so nothing fires out of reset
   always_ff @(posedge cpu_clk) begin
      if (reset) begin
         vio_q     <= 1'b0;
         rnw_q     <= 1'b0;
         address_q <= '0;
      end else begin
         vio_q     <= vio;
         rnw_q     <= rnw;
         address_q <= address;
      end
   end

   // Write data only matters when vio_q is set
   always_ff @(posedge cpu_clk) begin
      dout_q <= cpu_dout;
   end

   // ------------------------------------------------------------------------
   // Read data steering
   // ------------------------------------------------------------------------

   // UART byte zero-extended to a full word
   assign cpu_din = uart_cs ? {{(DSIZE - 8){1'b0}}, uart_dout} : ram_dout;

endmodule

`default_nettype wire

/* rtl/hex_display.sv */
`default_nettype none

module hex_display #(
   // Cycles each digit stays lit
   parameter int DIGIT_CYCLES = 8
) (
   input  logic        cpu_clk,
   input  logic        reset,
   input  logic [15:0] value,
   output logic [6:0]  seg,
   output logic [3:0]  an
);

   import soc_pkg::*;

   localparam int SW = $clog2(DIGIT_CYCLES + 1);
   localparam logic [SW-1:0] SCAN_END = SW'(DIGIT_CYCLES - 1);

   logic [SW-1:0] scan_cnt;
   logic          digit_step;
   logic [1:0]    digit;
   logic [15:0]   value_q;
   logic [3:0]    nibble;

   // ------------------------------------------------------------------------
   // Scan timing
   // ------------------------------------------------------------------------

   assign digit_step = (scan_cnt == SCAN_END);

   always_ff @(posedge cpu_clk) begin
      if (reset) begin
         scan_cnt <= '0;
         digit    <= 2'd0;
         an       <= 4'b1110;
      end else if (digit_step) begin
         scan_cnt <= '0;
         digit    <= digit + 1'b1;
         // Active-low anode walks from digit 0 up to digit 3
         an       <= {an[2:0], an[3]};
      end else begin
         scan_cnt <= scan_cnt + 1'b1;
      end
   end

   // Snapshot of the shown value, taken as each digit lights
   always_ff @(posedge cpu_clk) begin
      if (reset || digit_step) begin
         value_q <= value;
      end
   end

   // ------------------------------------------------------------------------
   // Segment drive
   // ------------------------------------------------------------------------

   always_comb begin
      case (digit)
         2'd0:    nibble = value_q[3:0];
         2'd1:    nibble = value_q[7:4];
         2'd2:    nibble = value_q[11:8];
         default: nibble = value_q[15:12];
      endcase
   end

   assign seg = hex_to_seg(nibble);

endmodule

`default_nettype wire

/* rtl/uart.sv */
`default_nettype none

module uart #(
   // Bit time in cpu_clk cycles
   parameter int CLKS_PER_BIT = 16
) (
   input  logic       cpu_clk,
   input  logic       reset,
   // Registered bus access
   input  logic       cs,
   input  logic       rnw,
   input  logic       a0,
   input  logic [7:0] din,
   output logic [7:0] dout,
   // Serial lines
   input  logic       rxd,
   output logic       txd
);

   import soc_pkg::*;

   localparam int CW = $clog2(CLKS_PER_BIT + 1);
   localparam logic [CW-1:0] BIT_END  = CW'(CLKS_PER_BIT - 1);
   localparam logic [CW-1:0] HALF_END = CW'(CLKS_PER_BIT / 2 - 1);

   uart_tx_state_t tx_state;
   logic [CW-1:0]  tx_cnt;
   logic [2:0]     tx_bits;
   logic [7:0]     tx_shift;
   logic           tx_bit_done;
   logic           tx_load;

   uart_rx_state_t rx_state;
   logic [CW-1:0]  rx_cnt;
   logic [2:0]     rx_bits;
   logic [7:0]     rx_shift;
   logic [7:0]     rx_data;
   logic           rx_full;
   logic           rx_bit_done;
   logic           rx_rd;
   logic           rxd_meta;
   logic           rxd_sync;
   logic           rxd_prev;
   logic           rx_fall;
   logic [7:0]     status;

   // ------------------------------------------------------------------------
   // Register access
   // ------------------------------------------------------------------------

   // Data write only accepted when the transmitter is idle
   assign tx_load = cs && !rnw && (a0 == UART_DATA_REG) && (tx_state == TX_IDLE);
   // Data read empties the receive buffer
   assign rx_rd   = cs && rnw && (a0 == UART_DATA_REG);

   always_comb begin
      status = '0;
      status[STAT_TX_BUSY] = (tx_state != TX_IDLE);
      status[STAT_RX_FULL] = rx_full;
   end

   assign dout = (a0 == UART_STATUS_REG) ? status : rx_data;

   // ------------------------------------------------------------------------
   // Transmitter
   // ------------------------------------------------------------------------

   assign tx_bit_done = (tx_cnt == BIT_END);

   always_ff @(posedge cpu_clk) begin
      if (reset) begin
         tx_state <= TX_IDLE;
         tx_cnt   <= '0;
         tx_bits  <= '0;
      end else begin
         // Bit timer runs whenever a frame is in flight
         if (tx_state == TX_IDLE || tx_bit_done) begin
            tx_cnt <= '0;
         end else begin
            tx_cnt <= tx_cnt + 1'b1;
         end
         case (tx_state)
            TX_IDLE: begin
               if (tx_load) begin
                  tx_state <= TX_START;
               end
            end
            TX_START: begin
               if (tx_bit_done) begin
                  tx_state <= TX_DATA;
                  tx_bits  <= '0;
               end
            end
            TX_DATA: begin
               if (tx_bit_done) begin
                  if (tx_bits == 3'd7) begin
                     tx_state <= TX_STOP;
                  end else begin
                     tx_bits <= tx_bits + 1'b1;
                  end
               end
            end
            default: begin
               if (tx_bit_done) begin
                  tx_state <= TX_IDLE;
               end
            end
         endcase
      end
   end

   // LSB first, shifted out at each data bit boundary
   always_ff @(posedge cpu_clk) begin
      if (tx_load) begin
         tx_shift <= din;
      end else if (tx_state == TX_DATA && tx_bit_done) begin
         tx_shift <= {1'b0, tx_shift[7:1]};
      end
   end

   // Line idles high, start bit low
   assign txd = (tx_state == TX_START) ? 1'b0 :
                (tx_state == TX_DATA)  ? tx_shift[0] : 1'b1;

   // ------------------------------------------------------------------------
   // Receiver
   // ------------------------------------------------------------------------

   // Two-stage synchronizer plus edge history
   always_ff @(posedge cpu_clk) begin
      if (reset) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   assign rx_fall     = rxd_prev & ~rxd_sync;
   assign rx_bit_done = (rx_cnt == BIT_END);

   always_ff @(posedge cpu_clk) begin
      if (reset) begin
         rx_state <= RX_IDLE;
         rx_cnt   <= '0;
         rx_bits  <= '0;
      end else begin
         case (rx_state)
            RX_IDLE: begin
               rx_cnt <= '0;
               if (rx_fall) begin
                  rx_state <= RX_START;
               end
            end
            // Half a bit in, check the start bit is still low
            RX_START: begin
               if (rx_cnt == HALF_END) begin
                  rx_cnt   <= '0;
                  rx_bits  <= '0;
                  rx_state <= rxd_sync ? RX_IDLE : RX_DATA;
               end else begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (rx_bit_done) begin
                  rx_cnt <= '0;
                  if (rx_bits == 3'd7) begin
                     rx_state <= RX_STOP;
                  end else begin
                     rx_bits <= rx_bits + 1'b1;
                  end
               end else begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
            // Back to idle at mid stop bit, ready for the next edge
            default: begin
               if (rx_bit_done) begin
                  rx_cnt   <= '0;
                  rx_state <= RX_IDLE;
               end else begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
         endcase
      end
   end

   // Mid-bit samples, LSB arrives first
   always_ff @(posedge cpu_clk) begin
      if (rx_state == RX_DATA && rx_bit_done) begin
         rx_shift <= {rxd_sync, rx_shift[7:1]};
      end
      if (rx_state == RX_STOP && rx_bit_done) begin
         rx_data <= rx_shift;
      end
   end

   // New byte wins over a read in the same cycle
   always_ff @(posedge cpu_clk) begin
      if (reset) begin
         rx_full <= 1'b0;
      end else if (rx_state == RX_STOP && rx_bit_done) begin
         rx_full <= 1'b1;
      end else if (rx_rd) begin
         rx_full <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* rtl/block_ram.sv */
`default_nettype none

module block_ram #(
   parameter int RAM_ASIZE = soc_pkg::RAM_ASIZE
) (
   input  logic                      cpu_clk,
   input  logic                      cs,
   input  logic                      rnw,
   input  logic [RAM_ASIZE-1:0]      address,
   input  logic [soc_pkg::DSIZE-1:0] din,
   output logic [soc_pkg::DSIZE-1:0] dout
);

   import soc_pkg::*;

   // Storage, one word per location
   logic [DSIZE-1:0] mem [0:(1 << RAM_ASIZE) - 1];

   // Write at the edge that ends the access cycle
   always_ff @(posedge cpu_clk) begin
      if (cs && !rnw) begin
         mem[address] <= din;
      end
   end

   // Registered read port
   // Word appears in the cycle after the lookahead address
   // Write cycles return the old contents
   always_ff @(posedge cpu_clk) begin
      if (cs) begin
         dout <= mem[address];
      end
   end

endmodule

`default_nettype wire

/* rtl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

   // ------------------------------------------------------------------------
   // Bus widths
   // ------------------------------------------------------------------------

   // One data word
   localparam int DSIZE = 16;
   localparam int ASIZE = 16;
   // Default RAM depth, mirrored through all of memory space
   localparam int RAM_ASIZE = 10;

   // ------------------------------------------------------------------------
   // UART register map
   // ------------------------------------------------------------------------

   // Selected by registered address bit 0
   localparam logic UART_DATA_REG   = 1'b0;
   localparam logic UART_STATUS_REG = 1'b1;

   // Status bit positions, other bits read zero
   localparam int STAT_TX_BUSY = 0;
   localparam int STAT_RX_FULL = 1;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } uart_tx_state_t;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } uart_rx_state_t;

   // Nibble to active-low segments, bit 6 is g and bit 0 is a
   function automatic logic [6:0] hex_to_seg(input logic [3:0] nibble);
      logic [6:0] seg;
      case (nibble)
         4'h0: seg = 7'b1000000;
         4'h1: seg = 7'b1111001;
         4'h2: seg = 7'b0100100;
         4'h3: seg = 7'b0110000;
         4'h4: seg = 7'b0011001;
         4'h5: seg = 7'b0010010;
         4'h6: seg = 7'b0000010;
         4'h7: seg = 7'b1111000;
         4'h8: seg = 7'b0000000;
         4'h9: seg = 7'b0010000;
         4'ha: seg = 7'b0001000;
         4'hb: seg = 7'b0000011;
         4'hc: seg = 7'b1000110;
         4'hd: seg = 7'b0100001;
         4'he: seg = 7'b0000110;
         default: seg = 7'b0001110;
      endcase
      return seg;
   endfunction

endpackage

`default_nettype wire
